// File: ckong_io_top.f
verilog/ckong_pkg.sv
verilog/ps2_receiver.sv
verilog/key_joystick.sv
verilog/control_mapper.sv
verilog/sigma_delta_dac.sv
verilog/rgb_expander.sv
verilog/ckong_io_top.sv
tb/tb_clock_gen.sv
tb/ckong_io_tb.sv

// File: tb/ckong_io_tb.sv
`timescale 1ns/1ps

module ckong_io_tb import ckong_pkg::*; ();

	logic               clock_48, reset, ce_pix, ps2_clk, ps2_data, tv15khz_mode, hs, vs;
	logic [7:0]         joystick_0, joystick_1, controls;
	logic [31:0]        status;
	logic [1:0]         buttons, b;
	logic [AUDIO_W-1:0] audio;
	logic [2:0]         r, g;
	logic               up, down, left, right, fire, start1, start2, coin, core_reset;
	logic               audio_l, audio_r, vga_hs, vga_vs;
	logic [5:0]         vga_r, vga_g, vga_b;
	logic               odd_line, hs_seen, pix_dim;   // scanline model
	logic [15:0]        lfsr = 16'd26826;
	int                 errors = 0;
	int                 timeouts = 0;
	int                 count;

	tb_clock_gen clock_gen (.clock_48, .reset);

	ckong_io_top u_ckong_io_top (.*);

	assign controls = {coin, start2, start1, fire, right, left, down, up};

	a_audio_mono: assert property (@(posedge clock_48) audio_r === audio_l)
		else report_mismatch("audio_r", audio_r, audio_l);

	// ========================================================================
	// helpers
	// ========================================================================
	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("ERR %s got %h expected %h", name, got, want);
		errors++;
	endtask

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // galois step
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// joystick bits 0 right, 1 left, 2 down, 3 up, 4 fire
	function automatic logic [7:0] expected_controls(input logic [7:0] j0, j1,
			input logic upright);
		logic [4:0] s;
		s = j0[4:0] | j1[4:0];
		if (upright)
			return {3'b000, s[4], s[2], s[3], s[1], s[0]};
		return {3'b000, s[4], s[0], s[1], s[2], s[3]};
	endfunction

	function automatic logic [5:0] shaded(input logic [5:0] c, input logic [1:0] fx,
			input logic on);
		if (on && fx == FX_DIM50)
			return c / 2;
		if (on && fx == FX_DIM25)
			return c - c / 4;
		return c;
	endfunction

	// start, data lsb first, odd parity, stop
	task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			repeat (20) @(negedge clock_48);
			ps2_clk = 1'b0;
			repeat (20) @(negedge clock_48);
			ps2_clk = 1'b1;
		end
		repeat (20) @(negedge clock_48);
	endtask

	task automatic key_cycle(input logic [7:0] code, input logic ext, input int idx);
		logic [7:0] want;
		int n;
		for (int brk = 0; brk < 2; brk++) begin
			want = brk ? 8'h00 : 8'(1 << idx);
			if (ext)
				send_ps2(SC_EXTENDED, 1'b0);
			if (brk)
				send_ps2(SC_BREAK, 1'b0);
			send_ps2(code, 1'b0);
			for (n = 0; n < 500 && controls !== want; n++)
				@(negedge clock_48);
			assert (controls === want) else begin
				$display("controls never reached %h after key %h", want, code);
				timeouts++;
			end
		end
	endtask

	// ========================================================================
	// stimulus
	// ========================================================================
	initial begin
		{ce_pix, tv15khz_mode, hs, vs, r, g, b} = '0;
		{ps2_clk, ps2_data} = 2'b11;
		{joystick_0, joystick_1, status, buttons, audio} = '0;
		{odd_line, hs_seen, pix_dim} = '0;

		@(negedge clock_48);
		assert (core_reset === 1'b1) else report_mismatch("core_reset", core_reset, 1);
		assert ({controls, audio_l, vga_r, vga_g, vga_b, vga_hs, vga_vs} === '0) else begin
			$display("outputs not cleared during reset");
			errors++;
		end
		for (count = 0; count < 100 && reset; count++)
			@(negedge clock_48);
		assert (!reset) else begin
			$display("reset was never released");
			timeouts++;
		end

		repeat (16) begin
			status[ST_RESET] = 1'(take_bits(1));
			status[ST_RESET_CMD] = 1'(take_bits(1));
			buttons = 2'(take_bits(2));
			@(negedge clock_48);
			assert (core_reset === (status[ST_RESET] | status[ST_RESET_CMD] | buttons[1]))
				else report_mismatch("core_reset", core_reset,
					status[ST_RESET] | status[ST_RESET_CMD] | buttons[1]);
		end
		status = '0;
		buttons = '0;

		key_cycle(SC_FIRE, 1'b0, 4);
		key_cycle(SC_START1, 1'b0, 5);
		key_cycle(SC_START2, 1'b0, 6);
		key_cycle(SC_COIN, 1'b0, 7);
		key_cycle(SC_UP, 1'b1, 0);
		key_cycle(SC_DOWN, 1'b1, 1);
		key_cycle(SC_LEFT, 1'b1, 2);
		key_cycle(SC_RIGHT, 1'b1, 3);
		status[ST_UPRIGHT] = 1'b1;   // rotated cabinet
		key_cycle(SC_UP, 1'b1, 2);
		key_cycle(SC_DOWN, 1'b1, 3);
		key_cycle(SC_LEFT, 1'b1, 1);
		key_cycle(SC_RIGHT, 1'b1, 0);
		status[ST_UPRIGHT] = 1'b0;

		send_ps2(SC_FIRE, 1'b1);
		count = 0;
		repeat (200) begin
			@(negedge clock_48);
			count += (controls != 8'h00);
		end
		assert (count == 0) else begin
			$display("a frame with bad parity changed the controls");
			errors++;
		end
		key_cycle(SC_FIRE, 1'b0, 4);   // receiver back in step

		repeat (64) begin
			joystick_0 = 8'(take_bits(8));
			joystick_1 = 8'(take_bits(8));
			status[ST_UPRIGHT] = 1'(take_bits(1));
			@(negedge clock_48);
			assert (controls === expected_controls(joystick_0, joystick_1, status[ST_UPRIGHT]))
				else report_mismatch("controls", controls,
					expected_controls(joystick_0, joystick_1, status[ST_UPRIGHT]));
		end
		{joystick_0, joystick_1, status} = '0;

		repeat (3) begin
			audio = AUDIO_W'(take_bits(AUDIO_W));
			@(negedge clock_48);
			count = 0;
			repeat (1 << AUDIO_W) begin
				count += audio_l;
				@(negedge clock_48);
			end
			assert (count == audio) else report_mismatch("audio_l count", count, audio);
		end

		// ====================================================================
		// video with one pixel every other clock and hs high on the first of six
		// ====================================================================
		for (int cfg = 0; cfg < 5; cfg++) begin
			status[ST_FX_LO +: 2] = (cfg == 4) ? FX_DIM50 : 2'(3 - cfg);
			tv15khz_mode = (cfg == 4);
			for (int px = 0; px < 24; px++) begin
				{r, g, b, vs} = 9'(take_bits(9));
				hs = (px % 6 == 0);
				ce_pix = 1'b1;
				pix_dim = odd_line && !tv15khz_mode;
				if (hs && !hs_seen)
					odd_line = !odd_line;
				hs_seen = hs;
				@(negedge clock_48);
				ce_pix = 1'b0;
				assert (vga_r === shaded({r, r}, status[ST_FX_LO +: 2], pix_dim))
					else report_mismatch("vga_r", vga_r, shaded({r, r}, status[4:3], pix_dim));
				assert (vga_g === shaded({g, g}, status[ST_FX_LO +: 2], pix_dim))
					else report_mismatch("vga_g", vga_g, shaded({g, g}, status[4:3], pix_dim));
				assert (vga_b === shaded({b, b[0], b, b[0]}, status[ST_FX_LO +: 2], pix_dim))
					else report_mismatch("vga_b", vga_b,
						shaded({b, b[0], b, b[0]}, status[4:3], pix_dim));
				assert ({vga_hs, vga_vs} === {hs, vs})
					else report_mismatch("vga_hs,vga_vs", {vga_hs, vga_vs}, {hs, vs});
				@(negedge clock_48);
			end
		end

		$display("%0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock_48,
	output logic reset
);

	initial begin
		clock_48 = 1'b0;
		forever #2 clock_48 = ~clock_48;   // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clock_48);
		@(negedge clock_48);
		reset <= 1'b0;
	end

endmodule

// File: verilog/ckong_io_top.sv
`timescale 1ns/1ps

module ckong_io_top import ckong_pkg::*; (
	input  logic               clock_48,
	input  logic               reset,
	input  logic               ce_pix,
	input  logic               ps2_clk,
	input  logic               ps2_data,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic [31:0]        status,
	input  logic [1:0]         buttons,
	input  logic               tv15khz_mode,
	input  logic [AUDIO_W-1:0] audio,
	input  logic [2:0]         r,
	input  logic [2:0]         g,
	input  logic [1:0]         b,
	input  logic               hs,
	input  logic               vs,
	output logic               up,
	output logic               down,
	output logic               left,
	output logic               right,
	output logic               fire,
	output logic               start1,
	output logic               start2,
	output logic               coin,
	output logic               core_reset,
	output logic               audio_l,
	output logic               audio_r,
	output logic [5:0]         vga_r,
	output logic [5:0]         vga_g,
	output logic [5:0]         vga_b,
	output logic               vga_hs,
	output logic               vga_vs
);

	logic [7:0]         byte_data;
	logic               byte_valid;
	logic [KBJOY_W-1:0] kbjoy;

	// ========================================================================
	// keyboard and player controls
	// ========================================================================
	ps2_receiver ps2_receiver (.clock_48, .reset, .ps2_clk, .ps2_data, .byte_data, .byte_valid);

	key_joystick key_joystick (.clock_48, .reset, .byte_data, .byte_valid, .kbjoy);

	control_mapper control_mapper (
		.clock_48, .reset, .kbjoy, .joystick_0, .joystick_1, .status, .buttons,
		.up, .down, .left, .right, .fire, .start1, .start2, .coin, .core_reset
	);

	// ========================================================================
	// audio and video
	// ========================================================================
	sigma_delta_dac sigma_delta_dac (.clock_48, .reset, .audio, .audio_l);

	assign audio_r = audio_l;   // mono core

	rgb_expander rgb_expander (
		.clock_48, .reset, .ce_pix, .r, .g, .b, .hs, .vs, .tv15khz_mode,
		.fx(status[ST_FX_LO +: 2]),
		.vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs
	);

endmodule

// File: verilog/rgb_expander.sv
`timescale 1ns/1ps

module rgb_expander import ckong_pkg::*; (
	input  logic       clock_48,
	input  logic       reset,
	input  logic       ce_pix,
	input  logic [2:0] r,
	input  logic [2:0] g,
	input  logic [1:0] b,
	input  logic       hs,
	input  logic       vs,
	input  logic       tv15khz_mode,
	input  logic [1:0] fx,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic [2:0] b3;
	logic       hs_prev;
	logic       line_odd;
	logic       dim;

	function automatic logic [5:0] shade(input logic [5:0] c, input logic [1:0] mode);
		case (mode)
			FX_DIM50: shade = c >> 1;
			FX_DIM25: shade = c - (c >> 2);
			FX_NONE, FX_HQ: shade = c;   // hq2x is not available here
			default: shade = c;
		endcase
	endfunction

	assign b3  = {b, b[0]};
	assign dim = line_odd && !tv15khz_mode;   // no scanlines on a 15 kHz display

	// ========================================================================
	// pixel pipeline with one ce_pix of latency
	// ========================================================================
	always_ff @(posedge clock_48) begin
		if (reset) begin
			hs_prev  <= 1'b0;
			line_odd <= 1'b0;
			{vga_r, vga_g, vga_b} <= '0;
			{vga_hs, vga_vs} <= '0;
		end else if (ce_pix) begin
			hs_prev <= hs;
			if (hs && !hs_prev)
				line_odd <= !line_odd;
			vga_r  <= dim ? shade({r, r}, fx) : {r, r};
			vga_g  <= dim ? shade({g, g}, fx) : {g, g};
			vga_b  <= dim ? shade({b3, b3}, fx) : {b3, b3};
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

endmodule

// File: verilog/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac import ckong_pkg::*; (
	input  logic               clock_48,
	input  logic               reset,
	input  logic [AUDIO_W-1:0] audio,
	output logic               audio_l
);

	logic [AUDIO_W:0] acc;   // top bit is the carry out

	// first order modulator whose carry rate equals audio / 2^AUDIO_W
	always_ff @(posedge clock_48) begin
		if (reset)
			acc <= '0;
		else
			acc <= {1'b0, acc[AUDIO_W-1:0]} + {1'b0, audio};
	end

	assign audio_l = acc[AUDIO_W];

	a_zero_quiet: assert property (@(posedge clock_48) disable iff (reset)
		(audio == '0) [*2] |=> !audio_l)
		else $error("dac output toggles on a silent sample");

endmodule

// File: verilog/control_mapper.sv
`timescale 1ns/1ps

module control_mapper import ckong_pkg::*; (
	input  logic               clock_48,
	input  logic               reset,
	input  logic [KBJOY_W-1:0] kbjoy,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic [31:0]        status,
	input  logic [1:0]         buttons,
	output logic               up,
	output logic               down,
	output logic               left,
	output logic               right,
	output logic               fire,
	output logic               start1,
	output logic               start2,
	output logic               coin,
	output logic               core_reset
);

	logic src_up, src_down, src_left, src_right;
	logic upright;

	// joystick bits 0 right, 1 left, 2 down, 3 up, 4 fire
	assign src_right = kbjoy[KJ_RIGHT] | joystick_0[0] | joystick_1[0];
	assign src_left  = kbjoy[KJ_LEFT]  | joystick_0[1] | joystick_1[1];
	assign src_down  = kbjoy[KJ_DOWN]  | joystick_0[2] | joystick_1[2];
	assign src_up    = kbjoy[KJ_UP]    | joystick_0[3] | joystick_1[3];
	assign upright   = status[ST_UPRIGHT];

	always_ff @(posedge clock_48) begin
		if (reset) begin
			{up, down, left, right} <= '0;
			{fire, start1, start2, coin} <= '0;
			core_reset <= 1'b1;
		end else begin
			up     <= upright ? src_right : src_up;   // cabinet rotated 90 degrees
			down   <= upright ? src_left  : src_down;
			left   <= upright ? src_up    : src_left;
			right  <= upright ? src_down  : src_right;
			fire   <= kbjoy[KJ_FIRE] | joystick_0[4] | joystick_1[4];
			start1 <= kbjoy[KJ_START1];
			start2 <= kbjoy[KJ_START2];
			coin   <= kbjoy[KJ_COIN];
			core_reset <= status[ST_RESET] | status[ST_RESET_CMD] | buttons[1];
		end
	end

	a_up_down_excl: assert property (@(posedge clock_48) disable iff (reset)
		(up && down) |-> $past(upright ? (src_right && src_left) : (src_up && src_down)))
		else $error("up and down both set without both sources");

endmodule

// File: verilog/key_joystick.sv
`timescale 1ns/1ps

module key_joystick import ckong_pkg::*; (
	input  logic               clock_48,
	input  logic               reset,
	input  logic [7:0]         byte_data,
	input  logic               byte_valid,
	output logic [KBJOY_W-1:0] kbjoy
);

	logic brk;   // F0 seen
	logic ext;   // E0 seen

	always_ff @(posedge clock_48) begin
		if (reset) begin
			brk   <= 1'b0;
			ext   <= 1'b0;
			kbjoy <= '0;
		end else if (byte_valid) begin
			if (byte_data == SC_BREAK) begin
				brk <= 1'b1;
			end else if (byte_data == SC_EXTENDED) begin
				ext <= 1'b1;
			end else begin
				brk <= 1'b0;
				ext <= 1'b0;
				if (ext) begin
					case (byte_data)
						SC_UP:    kbjoy[KJ_UP]    <= !brk;
						SC_DOWN:  kbjoy[KJ_DOWN]  <= !brk;
						SC_LEFT:  kbjoy[KJ_LEFT]  <= !brk;
						SC_RIGHT: kbjoy[KJ_RIGHT] <= !brk;
						default: ;   // other extended keys ignored
					endcase
				end else begin
					case (byte_data)
						SC_FIRE:   kbjoy[KJ_FIRE]   <= !brk;
						SC_START1: kbjoy[KJ_START1] <= !brk;
						SC_START2: kbjoy[KJ_START2] <= !brk;
						SC_COIN:   kbjoy[KJ_COIN]   <= !brk;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: verilog/ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver import ckong_pkg::*; (
	input  logic       clock_48,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] byte_data,
	output logic       byte_valid
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_filt;
	logic [$clog2(PS2_FILTER_LEN)-1:0] filt_cnt;
	logic       fall;
	logic [9:0] shreg;     // start, data, parity
	logic [3:0] bit_cnt;
	logic       frame_ok;

	always_ff @(posedge clock_48) begin
		clk_sync  <= {clk_sync[0], ps2_clk};
		data_sync <= {data_sync[0], ps2_data};
	end

	// ========================================================================
	// clock glitch filter
	// ========================================================================
	always_ff @(posedge clock_48) begin
		if (reset) begin
			clk_filt <= 1'b1;   // idle high
			filt_cnt <= '0;
		end else if (clk_sync[1] == clk_filt) begin
			filt_cnt <= '0;
		end else if (filt_cnt == PS2_FILTER_LEN - 1) begin
			clk_filt <= clk_sync[1];
			filt_cnt <= '0;
		end else begin
			filt_cnt <= filt_cnt + 1'b1;
		end
	end

	assign fall = clk_filt && !clk_sync[1] && (filt_cnt == PS2_FILTER_LEN - 1);

	// ========================================================================
	// framing
	// ========================================================================
	assign frame_ok = !shreg[0] && (^shreg[9:1]) && data_sync[1];   // odd parity, stop high

	always_ff @(posedge clock_48) begin
		if (reset) begin
			bit_cnt    <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0;
					byte_valid <= frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock_48) begin
		if (fall) begin
			shreg <= {data_sync[1], shreg[9:1]};   // lsb first
			if (bit_cnt == 4'd10)
				byte_data <= shreg[8:1];
		end
	end

	a_valid_pulse: assert property (@(posedge clock_48) disable iff (reset)
		byte_valid |=> !byte_valid)
		else $error("byte_valid held longer than one cycle");

	a_bit_cnt_range: assert property (@(posedge clock_48) disable iff (reset)
		bit_cnt <= 4'd10)
		else $error("ps2 bit counter out of range");

endmodule

// File: verilog/ckong_pkg.sv
package ckong_pkg;

	// ========================================================================
	// widths and counts
	// ========================================================================
	localparam int AUDIO_W        = 13;
	localparam int KBJOY_W        = 12;
	localparam int PS2_FILTER_LEN = 8;   // equal samples to accept a ps2 clock level

	// ========================================================================
	// keyboard joystick bit positions
	// ========================================================================
	localparam int KJ_FIRE   = 0;
	localparam int KJ_START1 = 1;
	localparam int KJ_START2 = 2;
	localparam int KJ_COIN   = 3;
	localparam int KJ_LEFT   = 4;
	localparam int KJ_RIGHT  = 5;
	localparam int KJ_DOWN   = 6;
	localparam int KJ_UP     = 7;

	// set 2 scancodes
	localparam logic [7:0] SC_FIRE     = 8'h29;   // space
	localparam logic [7:0] SC_START1   = 8'h16;
	localparam logic [7:0] SC_START2   = 8'h1E;
	localparam logic [7:0] SC_COIN     = 8'h2E;
	localparam logic [7:0] SC_UP       = 8'h75;   // arrows come after E0
	localparam logic [7:0] SC_DOWN     = 8'h72;
	localparam logic [7:0] SC_LEFT     = 8'h6B;
	localparam logic [7:0] SC_RIGHT    = 8'h74;
	localparam logic [7:0] SC_EXTENDED = 8'hE0;
	localparam logic [7:0] SC_BREAK    = 8'hF0;

	// status word from the config link
	localparam int ST_RESET     = 0;
	localparam int ST_UPRIGHT   = 2;
	localparam int ST_FX_LO     = 3;   // fx field is status[4:3]
	localparam int ST_RESET_CMD = 6;

	localparam logic [1:0] FX_NONE  = 2'd0;
	localparam logic [1:0] FX_HQ    = 2'd1;
	localparam logic [1:0] FX_DIM25 = 2'd2;
	localparam logic [1:0] FX_DIM50 = 2'd3;

endpackage
